/* flist.f */
design/cpuPkg.sv
design/controlSequencer.sv
design/registerFile.sv
design/arithUnit.sv
design/memoryPort.sv
design/dataPath.sv
design/cpuTop.sv
bench/cpuBus_assertions.sv
bench/cpuTb.sv

/* bench/cpuTb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuTb;

    import cpuPkg::*;

    localparam int          addrWidth  = 9;
    localparam int          cycleLimit = 20000;  // Tests need under 2000 cycles plus host loading
    localparam logic [31:0] seed       = 32'h093a_7d1e;

    logic                 clock;
    logic                 rst;
    logic                 start;
    logic                 busy;
    logic                 hostWrite;
    logic [addrWidth-1:0] hostAddr;
    logic [wordWidth-1:0] hostWriteData;
    logic [wordWidth-1:0] hostReadData;
    logic [wordWidth-1:0] progWords [$];
    int                   cycleCount;

    cpuTop #(
        .addrWidth (addrWidth)
    ) dut (
        .clock         (clock),
        .rst           (rst),
        .start         (start),
        .busy          (busy),
        .hostWrite     (hostWrite),
        .hostAddr      (hostAddr),
        .hostWriteData (hostWriteData),
        .hostReadData  (hostReadData)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge clock);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
        $display("Some tests failed");
        $fatal(1, "Cycle limit reached");
    end

    function automatic logic [wordWidth-1:0] encImm(opcodeT op, int ra, int rb, int c);
        instrWordT w;
        w.imm.opcode = op;
        w.imm.ra     = ra[regIdxWidth-1:0];
        w.imm.rb     = rb[regIdxWidth-1:0];
        w.imm.c      = c[constWidth-1:0];  // Low 19 bits of a signed constant
        return w;
    endfunction

    function automatic logic [wordWidth-1:0] encReg(opcodeT op, int ra, int rb, int rc);
        instrWordT w;
        w.regs.opcode = op;
        w.regs.ra     = ra[regIdxWidth-1:0];
        w.regs.rb     = rb[regIdxWidth-1:0];
        w.regs.rc     = rc[regIdxWidth-1:0];
        w.regs.unused = '0;
        return w;
    endfunction

    task automatic checkWord(input string testName, input logic [wordWidth-1:0] expected,
                             input logic [wordWidth-1:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", testName, expected, actual);
            $display("Some tests failed");
            $fatal(1, "Word mismatch in %s", testName);
        end
    endtask

    task automatic checkBusy(input string testName, input logic expected);
        if (busy !== expected) begin
            $display("Fail %s: expected busy %b, actual busy %b", testName, expected, busy);
            $display("Some tests failed");
            $fatal(1, "Busy mismatch in %s", testName);
        end
    endtask

    task automatic resetCpu();
        @(negedge clock);
        rst = 1'b1;
        repeat (4) @(negedge clock);
        rst = 1'b0;
    endtask

    task automatic pokeWord(input int addr, input logic [wordWidth-1:0] data);
        @(negedge clock);
        hostWrite     = 1'b1;
        hostAddr      = addr[addrWidth-1:0];
        hostWriteData = data;
        @(negedge clock);
        hostWrite = 1'b0;
    endtask

    task automatic checkMem(input string testName, input int addr,
                            input logic [wordWidth-1:0] expected);
        @(negedge clock);
        hostAddr = addr[addrWidth-1:0];
        @(posedge clock);  // Combinational read path has settled by now
        checkWord(testName, expected, hostReadData);
    endtask

    // Program sits at address 0 where reset leaves the PC
    task automatic loadAndRun(input string testName);
        resetCpu();
        foreach (progWords[i]) pokeWord(i, progWords[i]);
        @(negedge clock);
        start = 1'b1;
        @(negedge clock);
        start = 1'b0;
        checkBusy(testName, 1'b1);
        while (busy) @(negedge clock);
        @(negedge clock);
        checkBusy(testName, 1'b0);  // Stays idle after halt
    endtask

    task automatic testHostAndHalt();
        logic [wordWidth-1:0] word;
        word = $urandom;
        checkBusy("hostAndHalt", 1'b0);
        pokeWord(300, word);
        checkMem("hostAndHalt", 300, word);
        progWords = {encImm(opHalt, 0, 0, 0)};
        loadAndRun("hostAndHalt");
    endtask

    task automatic testZeroBase();
        progWords = {encImm(opLdi, 0, 0, 7),     // R0 itself holds 7
                     encImm(opLdi, 1, 0, 25),    // Base R0 counts as zero
                     encImm(opAddi, 2, 0, 1),    // Without baOut the real R0 is read
                     encImm(opSt, 1, 0, 100),
                     encImm(opSt, 2, 0, 101),
                     encImm(opHalt, 0, 0, 0)};
        loadAndRun("zeroBase");
        checkMem("zeroBase", 100, 25);
        checkMem("zeroBase", 101, 7 + 1);
    endtask

    task automatic testNegativeConst();
        progWords = {encImm(opLdi, 2, 0, 200000),
                     encImm(opLdi, 3, 2, -250000),
                     encImm(opLdi, 4, 0, -1),
                     encImm(opSt, 3, 0, 102),
                     encImm(opSt, 4, 0, 103),
                     encImm(opHalt, 0, 0, 0)};
        loadAndRun("negativeConst");
        checkMem("negativeConst", 102, 200000 + (-250000));
        checkMem("negativeConst", 103, 32'hffff_ffff);
    endtask

    task automatic testAddSub();
        int a;
        int b;
        a = 150000;
        b = -200000;
        progWords = {encImm(opLdi, 1, 0, a),
                     encImm(opLdi, 2, 0, b),
                     encReg(opAdd, 3, 1, 2),
                     encReg(opSub, 4, 1, 2),
                     encReg(opSub, 5, 2, 1),
                     encReg(opAdd, 6, 2, 2),
                     encImm(opSt, 3, 0, 110),
                     encImm(opSt, 4, 0, 111),
                     encImm(opSt, 5, 0, 112),
                     encImm(opSt, 6, 0, 113),
                     encImm(opHalt, 0, 0, 0)};
        loadAndRun("addSub");
        checkMem("addSub", 110, a + b);
        checkMem("addSub", 111, a - b);
        checkMem("addSub", 112, b - a);
        checkMem("addSub", 113, b + b);
    endtask

    task automatic testLoadAddi();
        logic [wordWidth-1:0] data;
        data = 32'h7fff_fff0;
        pokeWord(250, data);
        progWords = {encImm(opLdi, 1, 0, 50),
                     encImm(opLd, 2, 1, 200),    // Address 50 + 200
                     encImm(opAddi, 3, 2, 100),  // Crosses into the sign bit
                     encImm(opSt, 3, 0, 120),
                     encImm(opHalt, 0, 0, 0)};
        loadAndRun("loadAddi");
        checkMem("loadAddi", 120, data + 100);
    endtask

    task automatic testRandomLoads();
        logic [wordWidth-1:0] data [10];
        int                   consts [10];
        progWords = {};
        for (int i = 0; i < 10; i++) begin
            data[i]   = $urandom;
            consts[i] = int'($urandom_range(2**19 - 1, 0)) - 2**18;  // Full signed 19-bit range
            pokeWord(300 + i, data[i]);
            progWords.push_back(encImm(opLd, 1, 0, 300 + i));
            progWords.push_back(encImm(opAddi, 2, 1, consts[i]));
            progWords.push_back(encImm(opSt, 2, 0, 340 + i));
        end
        progWords.push_back(encImm(opHalt, 0, 0, 0));
        loadAndRun("randomLoads");
        for (int i = 0; i < 10; i++) begin
            checkMem("randomLoads", 340 + i, data[i] + consts[i]);
        end
    endtask

    initial begin
        void'($urandom(seed));
        rst           = 1'b1;
        start         = 1'b0;
        hostWrite     = 1'b0;
        hostAddr      = '0;
        hostWriteData = '0;
        resetCpu();
        testHostAndHalt();
        testZeroBase();
        testNegativeConst();
        testAddSub();
        testLoadAddi();
        testRandomLoads();
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/cpuBus_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuBusAssertions (
    input wire logic clock,
    input wire logic rst,
    input wire logic busy,
    input wire logic pcOut,
    input wire logic zLowOut,
    input wire logic mdrOut,
    input wire logic rOut,
    input wire logic cSignOut,
    input wire logic pcIn,
    input wire logic irIn,
    input wire logic marIn,
    input wire logic mdrIn,
    input wire logic yIn,
    input wire logic zIn,
    input wire logic rIn,
    input wire logic gra,
    input wire logic grb,
    input wire logic grc,
    input wire logic baOut,
    input wire logic read,
    input wire logic write,
    input wire logic marClear
);

    logic [4:0] sources;
    logic       anyStrobe;

    assign sources   = {pcOut, zLowOut, mdrOut, rOut, cSignOut};
    assign anyStrobe = |{sources, pcIn, irIn, marIn, mdrIn, yIn, zIn, rIn,
                         gra, grb, grc, baOut, read, write, marClear};

    singleBusSource: assert property (@(posedge clock) disable iff (rst) $onehot0(sources))
        else $error("More than one source drives the bus");

    noReadWithWrite: assert property (@(posedge clock) disable iff (rst) !(read && write))
        else $error("read and write are high together");

    regWriteSelected: assert property (@(posedge clock) disable iff (rst)
        rIn |-> $onehot({gra, grb, grc}))
        else $error("rIn without exactly one register select");

    quietAfterReset: assert property (@(posedge clock) rst |=> !busy && !anyStrobe)
        else $error("busy or a strobe is high in the cycle after reset");

endmodule

bind controlSequencer cpuBusAssertions busChecks (.*);

`default_nettype wire

/* design/cpuTop.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuTop #(
    parameter int addrWidth = 9  // 512 words of RAM
) (
    input  wire logic                         clock,
    input  wire logic                         rst,
    input  wire logic                         start,
    output logic                              busy,
    input  wire logic                         hostWrite,
    input  wire logic [addrWidth-1:0]         hostAddr,
    input  wire logic [cpuPkg::wordWidth-1:0] hostWriteData,
    output logic      [cpuPkg::wordWidth-1:0] hostReadData
);

    import cpuPkg::*;

    logic   pcOut, zLowOut, mdrOut, rOut, cSignOut;
    logic   pcIn, irIn, marIn, mdrIn, yIn, zIn, rIn;
    logic   gra, grb, grc, baOut;
    logic   read, write, marClear;
    aluOpT  aluOp;
    opcodeT opcode;

    controlSequencer ctrl (
        .clock    (clock),
        .rst      (rst),
        .start    (start),
        .opcode   (opcode),
        .busy     (busy),
        .pcOut    (pcOut),
        .zLowOut  (zLowOut),
        .mdrOut   (mdrOut),
        .rOut     (rOut),
        .cSignOut (cSignOut),
        .pcIn     (pcIn),
        .irIn     (irIn),
        .marIn    (marIn),
        .mdrIn    (mdrIn),
        .yIn      (yIn),
        .zIn      (zIn),
        .rIn      (rIn),
        .gra      (gra),
        .grb      (grb),
        .grc      (grc),
        .baOut    (baOut),
        .read     (read),
        .write    (write),
        .marClear (marClear),
        .aluOp    (aluOp)
    );

    dataPath #(
        .addrWidth (addrWidth)
    ) dp (
        .clock         (clock),
        .rst           (rst),
        .pcOut         (pcOut),
        .zLowOut       (zLowOut),
        .mdrOut        (mdrOut),
        .rOut          (rOut),
        .cSignOut      (cSignOut),
        .pcIn          (pcIn),
        .irIn          (irIn),
        .marIn         (marIn),
        .mdrIn         (mdrIn),
        .yIn           (yIn),
        .zIn           (zIn),
        .rIn           (rIn),
        .gra           (gra),
        .grb           (grb),
        .grc           (grc),
        .baOut         (baOut),
        .read          (read),
        .write         (write),
        .marClear      (marClear),
        .aluOp         (aluOp),
        .hostWrite     (hostWrite),
        .hostAddr      (hostAddr),
        .hostWriteData (hostWriteData),
        .hostReadData  (hostReadData),
        .opcode        (opcode)
    );

endmodule

`default_nettype wire

/* design/dataPath.sv */
`timescale 1ns/1ps
`default_nettype none

module dataPath #(
    parameter int addrWidth = 9
) (
    input  wire logic                         clock,
    input  wire logic                         rst,
    input  wire logic                         pcOut,
    input  wire logic                         zLowOut,
    input  wire logic                         mdrOut,
    input  wire logic                         rOut,
    input  wire logic                         cSignOut,
    input  wire logic                         pcIn,
    input  wire logic                         irIn,
    input  wire logic                         marIn,
    input  wire logic                         mdrIn,
    input  wire logic                         yIn,
    input  wire logic                         zIn,
    input  wire logic                         rIn,
    input  wire logic                         gra,
    input  wire logic                         grb,
    input  wire logic                         grc,
    input  wire logic                         baOut,
    input  wire logic                         read,
    input  wire logic                         write,
    input  wire logic                         marClear,
    input  cpuPkg::aluOpT                     aluOp,
    input  wire logic                         hostWrite,
    input  wire logic [addrWidth-1:0]         hostAddr,
    input  wire logic [cpuPkg::wordWidth-1:0] hostWriteData,
    output logic      [cpuPkg::wordWidth-1:0] hostReadData,
    output cpuPkg::opcodeT                    opcode
);

    import cpuPkg::*;

    logic [wordWidth-1:0] pc;
    instrWordT            ir;
    logic [wordWidth-1:0] bus;
    logic [wordWidth-1:0] cSign;
    logic [wordWidth-1:0] regOut;
    logic [wordWidth-1:0] zLow;
    logic [wordWidth-1:0] mdrValue;

    assign opcode = ir.imm.opcode;
    assign cSign  = {{(wordWidth - constWidth){ir.imm.c[constWidth-1]}}, ir.imm.c};

    // Sources are one-hot, the order only settles an idle bus
    always_comb begin
        if (pcOut)         bus = pc;
        else if (zLowOut)  bus = zLow;
        else if (mdrOut)   bus = mdrValue;
        else if (rOut)     bus = regOut;
        else if (cSignOut) bus = cSign;
        else               bus = '0;
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            pc <= '0;
            ir <= '0;
        end else begin
            if (pcIn) pc <= bus;
            if (irIn) ir <= bus;
        end
    end

    registerFile regFile (
        .clock  (clock),
        .rst    (rst),
        .ir     (ir),
        .gra    (gra),
        .grb    (grb),
        .grc    (grc),
        .rIn    (rIn),
        .baOut  (baOut),
        .busIn  (bus),
        .regOut (regOut)
    );

    arithUnit alu (
        .clock (clock),
        .rst   (rst),
        .busIn (bus),
        .yIn   (yIn),
        .zIn   (zIn),
        .aluOp (aluOp),
        .zLow  (zLow)
    );

    memoryPort #(
        .addrWidth (addrWidth)
    ) mem (
        .clock         (clock),
        .rst           (rst),
        .busIn         (bus),
        .marIn         (marIn),
        .marClear      (marClear),
        .mdrIn         (mdrIn),
        .read          (read),
        .write         (write),
        .hostWrite     (hostWrite),
        .hostAddr      (hostAddr),
        .hostWriteData (hostWriteData),
        .hostReadData  (hostReadData),
        .mdrValue      (mdrValue)
    );

endmodule

`default_nettype wire

/* design/memoryPort.sv */
`timescale 1ns/1ps
`default_nettype none

module memoryPort #(
    parameter int addrWidth = 9
) (
    input  wire logic                         clock,
    input  wire logic                         rst,
    input  wire logic [cpuPkg::wordWidth-1:0] busIn,
    input  wire logic                         marIn,
    input  wire logic                         marClear,
    input  wire logic                         mdrIn,
    input  wire logic                         read,
    input  wire logic                         write,
    input  wire logic                         hostWrite,
    input  wire logic [addrWidth-1:0]         hostAddr,
    input  wire logic [cpuPkg::wordWidth-1:0] hostWriteData,
    output logic      [cpuPkg::wordWidth-1:0] hostReadData,
    output logic      [cpuPkg::wordWidth-1:0] mdrValue
);

    import cpuPkg::*;

    logic [wordWidth-1:0] ram [2**addrWidth];
    logic [addrWidth-1:0] mar;

    assign hostReadData = ram[hostAddr];  // Meaningful only while idle

    always_ff @(posedge clock) begin
        if (rst) begin
            mar      <= '0;
            mdrValue <= '0;
        end else begin
            if (marClear) begin
                mar <= '0;
            end else if (marIn) begin
                mar <= busIn[addrWidth-1:0];  // Upper address bits dropped
            end
            if (read || mdrIn) begin
                mdrValue <= read ? ram[mar] : busIn;
            end
        end
    end

    // Processor store wins over the host path
    always_ff @(posedge clock) begin
        if (write) begin
            ram[mar] <= mdrValue;
        end else if (hostWrite) begin
            ram[hostAddr] <= hostWriteData;
        end
    end

endmodule

`default_nettype wire

/* design/arithUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module arithUnit (
    input  wire logic                         clock,
    input  wire logic                         rst,
    input  wire logic [cpuPkg::wordWidth-1:0] busIn,
    input  wire logic                         yIn,
    input  wire logic                         zIn,
    input  cpuPkg::aluOpT                     aluOp,
    output logic      [cpuPkg::wordWidth-1:0] zLow
);

    import cpuPkg::*;

    logic [wordWidth-1:0] yReg;
    logic [wordWidth-1:0] result;

    always_comb begin
        case (aluOp)
            aluAdd:  result = yReg + busIn;
            aluSub:  result = yReg - busIn;
            aluInc:  result = busIn + 1'b1;  // Y not involved
            default: result = yReg + busIn;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            yReg <= '0;
            zLow <= '0;
        end else begin
            if (yIn) yReg <= busIn;
            if (zIn) zLow <= result;
        end
    end

endmodule

`default_nettype wire

/* design/registerFile.sv */
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input  wire logic                         clock,
    input  wire logic                         rst,
    input  cpuPkg::instrWordT                 ir,
    input  wire logic                         gra,
    input  wire logic                         grb,
    input  wire logic                         grc,
    input  wire logic                         rIn,
    input  wire logic                         baOut,
    input  wire logic [cpuPkg::wordWidth-1:0] busIn,
    output logic      [cpuPkg::wordWidth-1:0] regOut
);

    import cpuPkg::*;

    logic [wordWidth-1:0]   regs [regCount];
    logic [regIdxWidth-1:0] sel;

    // Only one of the selects is active at a time, so OR-ing the fields encodes the index
    assign sel = ({regIdxWidth{gra}} & ir.imm.ra)
               | ({regIdxWidth{grb}} & ir.imm.rb)
               | ({regIdxWidth{grc}} & ir.regs.rc);

    assign regOut = (baOut && sel == '0) ? '0 : regs[sel];  // R0 as zero base

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (rIn) begin
            regs[sel] <= busIn;
        end
    end

endmodule

`default_nettype wire

/* design/controlSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module controlSequencer (
    input  wire logic           clock,
    input  wire logic           rst,
    input  wire logic           start,
    input  cpuPkg::opcodeT      opcode,
    output logic                busy,
    output logic                pcOut,
    output logic                zLowOut,
    output logic                mdrOut,
    output logic                rOut,
    output logic                cSignOut,
    output logic                pcIn,
    output logic                irIn,
    output logic                marIn,
    output logic                mdrIn,
    output logic                yIn,
    output logic                zIn,
    output logic                rIn,
    output logic                gra,
    output logic                grb,
    output logic                grc,
    output logic                baOut,
    output logic                read,
    output logic                write,
    output logic                marClear,
    output cpuPkg::aluOpT       aluOp
);

    import cpuPkg::*;

    typedef enum logic [3:0] {
        sIdle, sT0, sT1, sT2, sT3, sT4, sT5, sT6, sT7
    } stateT;

    stateT state;
    stateT nextState;

    logic usesBase;   // ld, ldi and st add R[rb] or zero to c
    logic shortOp;    // Three execute states
    logic regForm;    // Second operand comes from rc

    assign usesBase = (opcode == opLd) || (opcode == opLdi) || (opcode == opSt);
    assign regForm  = (opcode == opAdd) || (opcode == opSub);
    assign shortOp  = (opcode == opLdi) || (opcode == opAddi) || regForm;

    assign busy = (state != sIdle);

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= sIdle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            sIdle: if (start) nextState = sT0;
            sT0:   nextState = sT1;
            sT1:   nextState = sT2;
            sT2:   nextState = sT3;
            sT3:   nextState = (usesBase || shortOp) ? sT4 : sIdle;  // halt or unknown stops
            sT4:   nextState = sT5;
            sT5:   nextState = shortOp ? sT0 : sT6;
            sT6:   nextState = sT7;
            sT7:   nextState = sT0;
            default: nextState = sIdle;
        endcase
    end

    // Strobes decoded from the current state and the latched opcode
    always_comb begin
        pcOut    = 1'b0;
        zLowOut  = 1'b0;
        mdrOut   = 1'b0;
        rOut     = 1'b0;
        cSignOut = 1'b0;
        pcIn     = 1'b0;
        irIn     = 1'b0;
        marIn    = 1'b0;
        mdrIn    = 1'b0;
        yIn      = 1'b0;
        zIn      = 1'b0;
        rIn      = 1'b0;
        gra      = 1'b0;
        grb      = 1'b0;
        grc      = 1'b0;
        baOut    = 1'b0;
        read     = 1'b0;
        write    = 1'b0;
        marClear = 1'b0;
        aluOp    = aluAdd;
        case (state)
            sT0: begin
                pcOut = 1'b1;  // PC to MAR, Z gets PC + 1
                marIn = 1'b1;
                zIn   = 1'b1;
                aluOp = aluInc;
            end
            sT1: begin
                zLowOut = 1'b1;
                pcIn    = 1'b1;
                read    = 1'b1;  // Instruction word into MDR
            end
            sT2: begin
                mdrOut = 1'b1;
                irIn   = 1'b1;
            end
            sT3: begin
                if (usesBase || shortOp) begin
                    rOut  = 1'b1;
                    grb   = 1'b1;
                    baOut = usesBase;  // R0 reads as zero for address forming
                    yIn   = 1'b1;
                end else begin
                    marClear = 1'b1;  // halt parks the MAR
                end
            end
            sT4: begin
                zIn = 1'b1;
                if (regForm) begin
                    rOut  = 1'b1;
                    grc   = 1'b1;
                    aluOp = (opcode == opSub) ? aluSub : aluAdd;
                end else begin
                    cSignOut = 1'b1;
                end
            end
            sT5: begin
                zLowOut = 1'b1;
                if (shortOp) begin
                    gra = 1'b1;  // Result to Ra
                    rIn = 1'b1;
                end else begin
                    marIn = 1'b1;  // Effective address
                end
            end
            sT6: begin
                if (opcode == opSt) begin
                    rOut  = 1'b1;
                    gra   = 1'b1;
                    mdrIn = 1'b1;
                end else begin
                    read = 1'b1;
                end
            end
            sT7: begin
                if (opcode == opSt) begin
                    write = 1'b1;
                end else begin
                    mdrOut = 1'b1;
                    gra    = 1'b1;
                    rIn    = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* design/cpuPkg.sv */
`default_nettype none

package cpuPkg;

    localparam int wordWidth = 32;
    localparam int regCount = 16;
    localparam int opcodeWidth = 5;
    localparam int regIdxWidth = $clog2(regCount);
    localparam int constWidth = wordWidth - opcodeWidth - 2 * regIdxWidth;  // 19 bits
    localparam int spareWidth = constWidth - regIdxWidth;                  // Unused tail, rc format

    typedef enum logic [opcodeWidth-1:0] {
        opLd   = 5'b00000,
        opLdi  = 5'b00001,
        opSt   = 5'b00010,
        opAdd  = 5'b00011,
        opSub  = 5'b00100,
        opAddi = 5'b01100,
        opHalt = 5'b11011
    } opcodeT;

    typedef enum logic [1:0] {
        aluAdd = 2'b00,
        aluSub = 2'b01,
        aluInc = 2'b10  // Bus plus one, used for PC increment
    } aluOpT;

    // Base plus constant format
    typedef struct packed {
        opcodeT                 opcode;
        logic [regIdxWidth-1:0] ra;
        logic [regIdxWidth-1:0] rb;
        logic [constWidth-1:0]  c;
    } instrImmT;

    // Three register format
    typedef struct packed {
        opcodeT                 opcode;
        logic [regIdxWidth-1:0] ra;
        logic [regIdxWidth-1:0] rb;
        logic [regIdxWidth-1:0] rc;
        logic [spareWidth-1:0]  unused;
    } instrRegT;

    typedef union packed {
        instrImmT imm;
        instrRegT regs;
    } instrWordT;

endpackage

`default_nettype wire
